/* design/axiPkg.sv */
package axiPkg;

   // One AXI word on the bridge side
   typedef logic [63:0]  axiAddrT;
   typedef logic [127:0] axiDataT;
   typedef logic [1:0]   axiRespT;

   // Response codes
   localparam axiRespT RespOkay = 2'b00;

   // Bytes in one data beat, used to step block addresses
   localparam int BeatBytes = $bits(axiDataT) / 8;

endpackage

/* design/fetchPkg.sv */
package fetchPkg;

   import axiPkg::*;

   typedef logic [3:0] segmentT;

   // Segment field inside the pointer word
   localparam int      SegmentLsb  = 12;
   localparam segmentT SegmentLast = 4'd7;
   localparam segmentT SegmentInit = 4'd1;

   // Producer pointer locations
   localparam axiAddrT PtrReadAddr  = 64'h10;
   localparam axiAddrT PtrWriteAddr = 64'h0;

   localparam int BlockWords = 16;
   typedef logic [$clog2(BlockWords)-1:0] ramIdxT;

   // One poll every 2**PollCntWidth cycles
   localparam int PollCntWidth = 6;

   typedef enum logic [2:0] {
      Idle,
      LoadPtr,
      FetchWord,
      UpdatePtr,
      BlockHeld
   } fetchStateT;

endpackage

/* design/axiReadMaster.sv */
`timescale 1ns/1ps

module axiReadMaster
   import axiPkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    rdRqValid,
   input  axiAddrT rdRqAddr,
   output logic    rdRqDone,
   output axiDataT rdRqData,
   output logic    rdRqErr,
   output axiAddrT arAddr,
   output logic    arValid,
   input  logic    arReady,
   input  axiDataT rData,
   input  axiRespT rResp,
   input  logic    rValid,
   output logic    rReady
);

   typedef enum logic [1:0] {
      RdIdle,
      RdAddr,
      RdData
   } rdStateT;

   rdStateT state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= RdIdle;
         arValid  <= 1'b0;
         rReady   <= 1'b0;
         rdRqDone <= 1'b0;
         rdRqErr  <= 1'b0;
      end else begin
         rdRqDone <= 1'b0;
         case (state)
            RdIdle: begin
               if (rdRqValid) begin
                  arValid <= 1'b1;
                  state   <= RdAddr;
               end
            end
            RdAddr: begin
               if (arValid && arReady) begin
                  arValid <= 1'b0;
                  rReady  <= 1'b1;
                  state   <= RdData;
               end
            end
            RdData: begin
               if (rValid && rReady) begin
                  rReady   <= 1'b0;
                  rdRqDone <= 1'b1;
                  rdRqErr  <= (rResp != RespOkay);
                  state    <= RdIdle;
               end
            end
            default: state <= RdIdle;
         endcase
      end
   end

   // Request address and returned beat
   always_ff @(posedge clk) begin
      if (state == RdIdle && rdRqValid) begin
         arAddr <= rdRqAddr;
      end
      if (state == RdData && rValid && rReady) begin
         rdRqData <= rData;
      end
   end

   // AR payload holds until the slave takes it
   arAddrStable: assert property (
      @(posedge clk) disable iff (!rst_n)
      arValid && !arReady |=> arValid && $stable(arAddr)
   );

endmodule

/* design/axiWriteMaster.sv */
`timescale 1ns/1ps

module axiWriteMaster
   import axiPkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   input  logic    wrRqValid,
   input  axiAddrT wrRqAddr,
   input  axiDataT wrRqData,
   output logic    wrRqDone,
   output logic    wrRqErr,
   output axiAddrT awAddr,
   output logic    awValid,
   input  logic    awReady,
   output axiDataT wData,
   output logic    wValid,
   input  logic    wReady,
   input  axiRespT bResp,
   input  logic    bValid,
   output logic    bReady
);

   // AW and W complete independently, B only after both
   typedef enum logic [2:0] {
      WrIdle,
      WrBoth,
      WrAddrOnly,
      WrDataOnly,
      WrResp
   } wrStateT;

   wrStateT state;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= WrIdle;
         awValid  <= 1'b0;
         wValid   <= 1'b0;
         bReady   <= 1'b0;
         wrRqDone <= 1'b0;
         wrRqErr  <= 1'b0;
      end else begin
         wrRqDone <= 1'b0;
         case (state)
            WrIdle: begin
               if (wrRqValid) begin
                  awValid <= 1'b1;
                  wValid  <= 1'b1;
                  state   <= WrBoth;
               end
            end
            WrBoth: begin
               case ({awReady, wReady})
                  2'b11: begin
                     awValid <= 1'b0;
                     wValid  <= 1'b0;
                     bReady  <= 1'b1;
                     state   <= WrResp;
                  end
                  2'b10: begin
                     awValid <= 1'b0;
                     state   <= WrDataOnly;
                  end
                  2'b01: begin
                     wValid <= 1'b0;
                     state  <= WrAddrOnly;
                  end
                  default: state <= WrBoth;
               endcase
            end
            WrAddrOnly: begin
               if (awReady) begin
                  awValid <= 1'b0;
                  bReady  <= 1'b1;
                  state   <= WrResp;
               end
            end
            WrDataOnly: begin
               if (wReady) begin
                  wValid <= 1'b0;
                  bReady <= 1'b1;
                  state  <= WrResp;
               end
            end
            WrResp: begin
               if (bValid && bReady) begin
                  bReady   <= 1'b0;
                  wrRqDone <= 1'b1;
                  wrRqErr  <= (bResp != RespOkay);
                  state    <= WrIdle;
               end
            end
            default: state <= WrIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == WrIdle && wrRqValid) begin
         awAddr <= wrRqAddr;
         wData  <= wrRqData;
      end
   end

   // The engine waits for done before the next request
   noRqWhileBusy: assert property (
      @(posedge clk) disable iff (!rst_n)
      wrRqValid |-> state == WrIdle
   );

endmodule

/* design/inboundFetch.sv */
`timescale 1ns/1ps

module inboundFetch
   import axiPkg::*;
   import fetchPkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   output logic    rdRqValid,
   output axiAddrT rdRqAddr,
   input  logic    rdRqDone,
   input  axiDataT rdRqData,
   input  logic    rdRqErr,
   output logic    wrRqValid,
   output axiAddrT wrRqAddr,
   output axiDataT wrRqData,
   input  logic    wrRqDone,
   input  logic    wrRqErr,
   output logic    ramWrEn,
   output ramIdxT  ramWrIdx,
   output axiDataT ramWrData,
   output logic    blockValid,
   input  logic    blockRelease
);

   fetchStateT              state;
   fetchStateT              stateNext;
   logic [PollCntWidth-1:0] pollCnt;
   segmentT                 nextSeg;
   segmentT                 segInc;
   segmentT                 ptrSeg;
   ramIdxT                  wordIdx;
   axiAddrT                 blockBase;
   axiAddrT                 rdAddrNext;
   axiDataT                 wbWord;
   logic                    issueRd;
   logic                    issueWr;
   logic                    storeWord;
   logic                    wbDone;

   assign ptrSeg    = rdRqData[SegmentLsb +: $bits(segmentT)];
   assign blockBase = axiAddrT'(ptrSeg) << SegmentLsb;
   assign segInc    = (nextSeg == SegmentLast) ? '0 : nextSeg + segmentT'(1);
   assign wbDone    = (state == UpdatePtr) && wrRqDone && !wrRqErr;

   // Pointer word written back with only the segment field set
   always_comb begin
      wbWord = '0;
      wbWord[SegmentLsb +: $bits(segmentT)] = segInc;
   end

   always_comb begin
      stateNext  = state;
      issueRd    = 1'b0;
      issueWr    = 1'b0;
      storeWord  = 1'b0;
      rdAddrNext = rdRqAddr;
      case (state)
         Idle: begin
            if (pollCnt == '1) begin
               issueRd    = 1'b1;
               rdAddrNext = PtrReadAddr;
               stateNext  = LoadPtr;
            end
         end
         LoadPtr: begin
            if (rdRqDone) begin
               if (rdRqErr) begin
                  issueRd    = 1'b1;
                  rdAddrNext = PtrReadAddr;
               end else if (ptrSeg == nextSeg) begin
                  stateNext = Idle;
               end else begin
                  issueRd    = 1'b1;
                  rdAddrNext = blockBase;
                  stateNext  = FetchWord;
               end
            end
         end
         FetchWord: begin
            if (rdRqDone) begin
               if (rdRqErr) begin
                  // Same address again
                  issueRd = 1'b1;
               end else begin
                  storeWord = 1'b1;
                  if (wordIdx == ramIdxT'(BlockWords - 1)) begin
                     issueWr   = 1'b1;
                     stateNext = UpdatePtr;
                  end else begin
                     issueRd    = 1'b1;
                     rdAddrNext = rdRqAddr + axiAddrT'(BeatBytes);
                  end
               end
            end
         end
         UpdatePtr: begin
            if (wrRqDone) begin
               if (wrRqErr) begin
                  issueWr = 1'b1;
               end else begin
                  stateNext = BlockHeld;
               end
            end
         end
         BlockHeld: begin
            if (blockRelease) begin
               stateNext = Idle;
            end
         end
         default: stateNext = Idle;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state     <= Idle;
         pollCnt   <= '0;
         nextSeg   <= SegmentInit;
         wordIdx   <= '0;
         rdRqValid <= 1'b0;
         wrRqValid <= 1'b0;
         ramWrEn   <= 1'b0;
      end else begin
         state     <= stateNext;
         pollCnt   <= pollCnt + 1'b1;
         rdRqValid <= issueRd;
         wrRqValid <= issueWr;
         ramWrEn   <= storeWord;
         if (state == LoadPtr) begin
            wordIdx <= '0;
         end else if (storeWord) begin
            wordIdx <= wordIdx + 1'b1;
         end
         if (wbDone) begin
            nextSeg <= segInc;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issueRd) begin
         rdRqAddr <= rdAddrNext;
      end
      if (storeWord) begin
         ramWrIdx  <= wordIdx;
         ramWrData <= rdRqData;
      end
      if (issueWr) begin
         wrRqData <= wbWord;
      end
   end

   assign wrRqAddr   = PtrWriteAddr;
   assign blockValid = (state == BlockHeld);

   ramIdxInRange: assert property (
      @(posedge clk) disable iff (!rst_n)
      ramWrEn |-> int'(ramWrIdx) < BlockWords
   );

endmodule

/* design/inboundRam.sv */
`timescale 1ns/1ps

module inboundRam
   import axiPkg::*;
   import fetchPkg::*;
(
   input  logic    clk,
   input  logic    ramWrEn,
   input  ramIdxT  ramWrIdx,
   input  axiDataT ramWrData,
   input  logic    blockRdEn,
   input  ramIdxT  blockRdIdx,
   output axiDataT blockRdData
);

   axiDataT mem [BlockWords];

   // Engine side
   always_ff @(posedge clk) begin
      if (ramWrEn) begin
         mem[ramWrIdx] <= ramWrData;
      end
   end

   // Consumer side, one cycle read latency
   always_ff @(posedge clk) begin
      if (blockRdEn) begin
         blockRdData <= mem[blockRdIdx];
      end
   end

endmodule

/* design/pcieSubTop.sv */
`timescale 1ns/1ps

module pcieSubTop
   import axiPkg::*;
   import fetchPkg::*;
(
   input  logic    clk,
   input  logic    rst_n,
   output axiAddrT arAddr,
   output logic    arValid,
   input  logic    arReady,
   input  axiDataT rData,
   input  axiRespT rResp,
   input  logic    rValid,
   output logic    rReady,
   output axiAddrT awAddr,
   output logic    awValid,
   input  logic    awReady,
   output axiDataT wData,
   output logic    wValid,
   input  logic    wReady,
   input  axiRespT bResp,
   input  logic    bValid,
   output logic    bReady,
   output logic    blockValid,
   input  logic    blockRelease,
   input  logic    blockRdEn,
   input  ramIdxT  blockRdIdx,
   output axiDataT blockRdData
);

   logic    rdRqValid;
   axiAddrT rdRqAddr;
   logic    rdRqDone;
   axiDataT rdRqData;
   logic    rdRqErr;
   logic    wrRqValid;
   axiAddrT wrRqAddr;
   axiDataT wrRqData;
   logic    wrRqDone;
   logic    wrRqErr;
   logic    ramWrEn;
   ramIdxT  ramWrIdx;
   axiDataT ramWrData;

   axiReadMaster readMaster_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .rdRqValid (rdRqValid),
      .rdRqAddr  (rdRqAddr),
      .rdRqDone  (rdRqDone),
      .rdRqData  (rdRqData),
      .rdRqErr   (rdRqErr),
      .arAddr    (arAddr),
      .arValid   (arValid),
      .arReady   (arReady),
      .rData     (rData),
      .rResp     (rResp),
      .rValid    (rValid),
      .rReady    (rReady)
   );

   axiWriteMaster writeMaster_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .wrRqValid (wrRqValid),
      .wrRqAddr  (wrRqAddr),
      .wrRqData  (wrRqData),
      .wrRqDone  (wrRqDone),
      .wrRqErr   (wrRqErr),
      .awAddr    (awAddr),
      .awValid   (awValid),
      .awReady   (awReady),
      .wData     (wData),
      .wValid    (wValid),
      .wReady    (wReady),
      .bResp     (bResp),
      .bValid    (bValid),
      .bReady    (bReady)
   );

   inboundFetch fetch_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .rdRqValid    (rdRqValid),
      .rdRqAddr     (rdRqAddr),
      .rdRqDone     (rdRqDone),
      .rdRqData     (rdRqData),
      .rdRqErr      (rdRqErr),
      .wrRqValid    (wrRqValid),
      .wrRqAddr     (wrRqAddr),
      .wrRqData     (wrRqData),
      .wrRqDone     (wrRqDone),
      .wrRqErr      (wrRqErr),
      .ramWrEn      (ramWrEn),
      .ramWrIdx     (ramWrIdx),
      .ramWrData    (ramWrData),
      .blockValid   (blockValid),
      .blockRelease (blockRelease)
   );

   inboundRam ram_i (
      .clk         (clk),
      .ramWrEn     (ramWrEn),
      .ramWrIdx    (ramWrIdx),
      .ramWrData   (ramWrData),
      .blockRdEn   (blockRdEn),
      .blockRdIdx  (blockRdIdx),
      .blockRdData (blockRdData)
   );

endmodule

/* dv/axiMemModel.sv */
`timescale 1ns/1ps

module axiMemModel
   import axiPkg::*;
#(
   parameter logic [31:0] Seed = 32'h1
)
(
   input  logic    clk,
   input  logic    rst_n,
   input  axiAddrT arAddr,
   input  logic    arValid,
   output logic    arReady,
   output axiDataT rData,
   output axiRespT rResp,
   output logic    rValid,
   input  logic    rReady,
   input  axiAddrT awAddr,
   input  logic    awValid,
   output logic    awReady,
   input  axiDataT wData,
   input  logic    wValid,
   output logic    wReady,
   output axiRespT bResp,
   output logic    bValid,
   input  logic    bReady,
   input  axiDataT ptrWord,
   input  logic    injectRdErr,
   input  logic    injectWrErr,
   output logic    rdErrPending,
   output logic    wrErrPending,
   output axiAddrT lastWrAddr,
   output axiDataT lastWrData,
   output int      arCount,
   output int      awCount
);

   localparam axiRespT RespSlvErr = 2'b10;

   integer     seed;
   logic [1:0] arDelay;
   logic [1:0] rDelay;
   logic [1:0] awDelay;
   logic [1:0] wDelay;
   logic [1:0] bDelay;
   logic       rdBusy;
   logic       awGot;
   logic       wGot;
   axiAddrT    rdAddr;

   initial seed = Seed;

   // Every address holds a word derived from itself
   function automatic axiDataT memWord(input axiAddrT addr);
      logic [31:0] w;
      w = addr[31:0] ^ 32'hA5A5A5A5;
      return {w, w, w, w};
   endfunction

   function automatic logic [1:0] randDelay();
      integer r;
      r = $random(seed);
      return r[1:0];
   endfunction

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         arReady      <= 1'b0;
         rValid       <= 1'b0;
         rResp        <= RespOkay;
         rData        <= '0;
         awReady      <= 1'b0;
         wReady       <= 1'b0;
         bValid       <= 1'b0;
         bResp        <= RespOkay;
         arDelay      <= '0;
         rDelay       <= '0;
         awDelay      <= '0;
         wDelay       <= '0;
         bDelay       <= '0;
         rdBusy       <= 1'b0;
         awGot        <= 1'b0;
         wGot         <= 1'b0;
         rdErrPending <= 1'b0;
         wrErrPending <= 1'b0;
         arCount      <= 0;
         awCount      <= 0;
      end else begin
         // Read address
         if (arValid && arReady) begin
            arReady <= 1'b0;
            rdAddr  <= arAddr;
            rdBusy  <= 1'b1;
            rDelay  <= randDelay();
            arDelay <= randDelay();
            arCount <= arCount + 1;
         end else if (arValid && !rdBusy) begin
            if (arDelay == 0) begin
               arReady <= 1'b1;
            end else begin
               arDelay <= arDelay - 1'b1;
            end
         end
         // Read data
         if (rValid && rReady) begin
            rValid <= 1'b0;
            rdBusy <= 1'b0;
         end else if (rdBusy && !rValid) begin
            if (rDelay == 0) begin
               rValid <= 1'b1;
               if (rdErrPending) begin
                  // Failed beat carries a corrupted word
                  rData <= (rdAddr == 64'h10) ? ~ptrWord : ~memWord(rdAddr);
                  rResp <= RespSlvErr;
               end else begin
                  rData <= (rdAddr == 64'h10) ? ptrWord : memWord(rdAddr);
                  rResp <= RespOkay;
               end
               rdErrPending <= 1'b0;
            end else begin
               rDelay <= rDelay - 1'b1;
            end
         end
         // Write address and data taken independently
         if (awValid && awReady) begin
            awReady    <= 1'b0;
            awGot      <= 1'b1;
            lastWrAddr <= awAddr;
            awDelay    <= randDelay();
            awCount    <= awCount + 1;
         end else if (awValid && !awGot) begin
            if (awDelay == 0) begin
               awReady <= 1'b1;
            end else begin
               awDelay <= awDelay - 1'b1;
            end
         end
         if (wValid && wReady) begin
            wReady     <= 1'b0;
            wGot       <= 1'b1;
            lastWrData <= wData;
            wDelay     <= randDelay();
         end else if (wValid && !wGot) begin
            if (wDelay == 0) begin
               wReady <= 1'b1;
            end else begin
               wDelay <= wDelay - 1'b1;
            end
         end
         // Write response once both halves arrived
         if (bValid && bReady) begin
            bValid <= 1'b0;
            awGot  <= 1'b0;
            wGot   <= 1'b0;
         end else if (awGot && wGot && !bValid) begin
            if (bDelay == 0) begin
               bValid       <= 1'b1;
               bResp        <= wrErrPending ? RespSlvErr : RespOkay;
               wrErrPending <= 1'b0;
               bDelay       <= randDelay();
            end else begin
               bDelay <= bDelay - 1'b1;
            end
         end
         if (injectRdErr) begin
            rdErrPending <= 1'b1;
         end
         if (injectWrErr) begin
            wrErrPending <= 1'b1;
         end
      end
   end

endmodule

/* dv/pcieSubTb.sv */
`timescale 1ns/1ps

module pcieSubTb
   import axiPkg::*;
   import fetchPkg::*;
();

   localparam logic [31:0] RandSeed     = 32'h9be3e929;
   localparam int          PollPeriod   = 64;
   localparam int          BlockTimeout = 2000;
   localparam int          ReadTimeout  = 500;

   logic    clk;
   logic    rst_n;
   axiAddrT arAddr;
   logic    arValid;
   logic    arReady;
   axiDataT rData;
   axiRespT rResp;
   logic    rValid;
   logic    rReady;
   axiAddrT awAddr;
   logic    awValid;
   logic    awReady;
   axiDataT wData;
   logic    wValid;
   logic    wReady;
   axiRespT bResp;
   logic    bValid;
   logic    bReady;
   logic    blockValid;
   logic    blockRelease;
   logic    blockRdEn;
   ramIdxT  blockRdIdx;
   axiDataT blockRdData;
   axiDataT ptrWord;
   logic    injectRdErr;
   logic    injectWrErr;
   logic    rdErrPending;
   logic    wrErrPending;
   axiAddrT lastWrAddr;
   axiDataT lastWrData;
   int      arCount;
   int      awCount;

   // Segment the engine should hold as its next segment
   segmentT expSeg;

   pcieSubTop dut_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .arAddr       (arAddr),
      .arValid      (arValid),
      .arReady      (arReady),
      .rData        (rData),
      .rResp        (rResp),
      .rValid       (rValid),
      .rReady       (rReady),
      .awAddr       (awAddr),
      .awValid      (awValid),
      .awReady      (awReady),
      .wData        (wData),
      .wValid       (wValid),
      .wReady       (wReady),
      .bResp        (bResp),
      .bValid       (bValid),
      .bReady       (bReady),
      .blockValid   (blockValid),
      .blockRelease (blockRelease),
      .blockRdEn    (blockRdEn),
      .blockRdIdx   (blockRdIdx),
      .blockRdData  (blockRdData)
   );

   axiMemModel #(.Seed(RandSeed)) memModel_i (
      .clk          (clk),
      .rst_n        (rst_n),
      .arAddr       (arAddr),
      .arValid      (arValid),
      .arReady      (arReady),
      .rData        (rData),
      .rResp        (rResp),
      .rValid       (rValid),
      .rReady       (rReady),
      .awAddr       (awAddr),
      .awValid      (awValid),
      .awReady      (awReady),
      .wData        (wData),
      .wValid       (wValid),
      .wReady       (wReady),
      .bResp        (bResp),
      .bValid       (bValid),
      .bReady       (bReady),
      .ptrWord      (ptrWord),
      .injectRdErr  (injectRdErr),
      .injectWrErr  (injectWrErr),
      .rdErrPending (rdErrPending),
      .wrErrPending (wrErrPending),
      .lastWrAddr   (lastWrAddr),
      .lastWrData   (lastWrData),
      .arCount      (arCount),
      .awCount      (awCount)
   );

   always #20 clk = ~clk;

   task automatic failRun(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic checkAddr(input axiAddrT got, input axiAddrT exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("Error at %0t ns: %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic checkData(input axiDataT got, input axiDataT exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("Error at %0t ns: %s got %h expected %h", $time, what, got, exp));
      end
   endtask

   task automatic checkSeg(input segmentT got, input segmentT exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("Error at %0t ns: %s got %0d expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic checkBit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         failRun($sformatf("Error at %0t ns: %s got %b expected %b", $time, what, got, exp));
      end
   endtask

   // Segment in bits 15:12 with the other bits filled
   function automatic axiDataT pointerWord(input segmentT seg);
      axiDataT word;
      word = {96'h0123_4567_89ab_cdef_0246_8ace, 16'h7e3d, 4'h0, 12'h9c1};
      word[15:12] = seg;
      return word;
   endfunction

   function automatic axiDataT expectedWord(input axiAddrT addr, input axiDataT ptr);
      logic [31:0] w;
      w = addr[31:0] ^ 32'hA5A5A5A5;
      if (addr == 64'h10) begin
         return ptr;
      end
      return {w, w, w, w};
   endfunction

   task automatic waitBlockValid();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > BlockTimeout) begin
            failRun("Timeout: blockValid never rose after the pointer changed");
         end
      end while (!blockValid);
   endtask

   task automatic waitBlockClear();
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > 10) begin
            failRun("Timeout: blockValid stayed high after release");
         end
      end while (blockValid);
   endtask

   task automatic waitReadAddr(input axiAddrT addr);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         n++;
         if (n > ReadTimeout) begin
            failRun($sformatf("Timeout: no read request seen at address %h", addr));
         end
      end while (!(arValid && arAddr == addr));
   endtask

   task automatic pulseErrors(input logic rd, input logic wr);
      @(posedge clk);
      injectRdErr <= rd;
      injectWrErr <= wr;
      @(posedge clk);
      injectRdErr <= 1'b0;
      injectWrErr <= 1'b0;
   endtask

   task automatic readRamWord(input ramIdxT idx, output axiDataT data);
      @(posedge clk);
      blockRdEn  <= 1'b1;
      blockRdIdx <= idx;
      @(posedge clk);
      blockRdEn <= 1'b0;
      @(negedge clk);
      data = blockRdData;
   endtask

   task automatic releaseBlock();
      @(posedge clk);
      blockRelease <= 1'b1;
      @(posedge clk);
      blockRelease <= 1'b0;
      waitBlockClear();
   endtask

   task automatic checkResetState();
      @(negedge clk);
      checkBit(arValid, 1'b0, "arValid after reset");
      checkBit(rReady, 1'b0, "rReady after reset");
      checkBit(awValid, 1'b0, "awValid after reset");
      checkBit(wValid, 1'b0, "wValid after reset");
      checkBit(bReady, 1'b0, "bReady after reset");
      checkBit(blockValid, 1'b0, "blockValid after reset");
   endtask

   // Polls stay quiet while the pointer matches the next segment
   task automatic checkIdlePolls();
      repeat (4 * PollPeriod) begin
         @(negedge clk);
         checkBit(blockValid, 1'b0, "blockValid while pointer matches");
      end
      checkBit(awCount == 0, 1'b1, "no write while pointer matches");
      checkBit(arCount >= 3, 1'b1, "pointer polls issued");
   endtask

   // Producer moves the pointer one segment ahead
   task automatic runBlock(input logic rdErr, input logic wrErr, input logic midErr);
      segmentT wbSeg;
      axiAddrT base;
      axiDataT ptr;
      axiDataT expWb;
      axiDataT got;
      int      i;
      int      wrBefore;
      wrBefore = awCount;
      wbSeg = (expSeg == 4'd7) ? 4'd0 : expSeg + 4'd1;
      base  = axiAddrT'(wbSeg) << 12;
      ptr   = pointerWord(wbSeg);
      if (rdErr || wrErr) begin
         pulseErrors(rdErr, wrErr);
      end
      @(posedge clk);
      ptrWord <= ptr;
      if (midErr) begin
         waitReadAddr(base + 64'h50);
         pulseErrors(1'b1, 1'b0);
      end
      waitBlockValid();
      checkAddr(lastWrAddr, 64'h0, "write-back address");
      expWb = '0;
      expWb[15:12] = wbSeg;
      checkData(lastWrData, expWb, "write-back data");
      checkSeg(lastWrData[15:12], wbSeg, "written segment");
      checkBit(rdErrPending, 1'b0, "injected read error delivered");
      checkBit(wrErrPending, 1'b0, "injected write error delivered");
      checkBit((awCount - wrBefore) == (wrErr ? 2 : 1), 1'b1, "write-back attempts");
      for (i = 0; i < 16; i++) begin
         readRamWord(ramIdxT'(i), got);
         checkData(got, expectedWord(base + axiAddrT'(16 * i), ptr),
                   $sformatf("RAM word %0d", i));
      end
      expSeg = wbSeg;
      releaseBlock();
   endtask

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      blockRelease = 1'b0;
      blockRdEn    = 1'b0;
      blockRdIdx   = '0;
      injectRdErr  = 1'b0;
      injectWrErr  = 1'b0;
      ptrWord      = pointerWord(4'd1);
      expSeg       = 4'd1;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      checkResetState();
      checkIdlePolls();
      // First block at segment 2
      runBlock(1'b0, 1'b0, 1'b0);
      // Segments 3 to 7 and the wrap to 0
      repeat (6) begin
         runBlock(1'b0, 1'b0, 1'b0);
      end
      checkSeg(lastWrData[15:12], 4'd0, "segment after wrap");
      // Retried responses
      runBlock(1'b1, 1'b1, 1'b0);
      runBlock(1'b0, 1'b0, 1'b1);
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* project.f */
design/axiPkg.sv
design/fetchPkg.sv
design/axiReadMaster.sv
design/axiWriteMaster.sv
design/inboundFetch.sv
design/inboundRam.sv
design/pcieSubTop.sv
dv/axiMemModel.sv
dv/pcieSubTb.sv
